//--- list.f
+incdir+src
src/display_pkg.sv
src/glyph_pkg.sv
src/vga_scan_if.sv
src/vga_timing.sv
src/glyph_render.sv
src/tspin_alert_timer.sv
src/tspin_text_overlay.sv
src/tspin_alert_display.sv
tb/tspin_alert_asserts.sv
tb/tb_tspin_alert_display.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_tspin_alert_display -f list.f -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -qF "** FAIL **" sim.log && { echo "simulation failed"; exit 1; }
grep -qF "** PASS **" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- tb/tb_tspin_alert_display.sv
// directed tests for the alert overlay at the 640x480 timing of the defines
// a scan model follows every output pixel and is checked at each sync edge
`timescale 1ns/1ps
`include "display_defines.svh"

module tb_tspin_alert_display;
    import display_pkg::*;

    localparam int     CLK_PERIOD_NS = 4;
    localparam int     RESET_CYCLES  = 16;
    localparam int     NUM_TESTS     = 5;
    localparam longint FRAME_NS      = longint'(`H_TOTAL) * `V_TOTAL * CLK_PERIOD_NS;
    localparam longint TIMEOUT_NS    = (NUM_TESTS * 6 + 1) * FRAME_NS;
    localparam int     HSYNC_COL     = `H_ACTIVE + `H_FRONT;   // first column of hsync low
    localparam int     VSYNC_ROW     = `V_ACTIVE + `V_FRONT;
    localparam int     GLYPH_W       = 5 * `GLYPH_SCALE;        // 5x7 font scaled up
    localparam int     GLYPH_H       = 7 * `GLYPH_SCALE;
    localparam int     PULSE_COL     = 8;
    localparam int     RESTART_ROW   = 100;
    localparam int     NO_PULSE      = -1;

    logic clk;
    logic arst_n;
    logic tspin_detected;
    rgb_t vga_rgb;
    logic vga_hsync;
    logic vga_vsync;
    logic vga_de;

    // scan model state, position of the pixel now on the outputs
    int   pix_row;
    int   pix_col;
    bit   pix_valid;
    logic prev_hsync;
    logic prev_vsync;
    bit   hsync_fell;
    bit   hsync_rose;
    bit   vsync_fell;
    bit   vsync_rose;

    tspin_alert_display i_tspin_alert_display (
        .clk            (clk),
        .arst_n         (arst_n),
        .tspin_detected (tspin_detected),
        .vga_rgb        (vga_rgb),
        .vga_hsync      (vga_hsync),
        .vga_vsync      (vga_vsync),
        .vga_de         (vga_de)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic report_failure(input string what);
        $display("at %0t ns: %s", $time, what);
        abort_run();
    endtask

    // one clock forward; outputs are stable at the falling edge
    task automatic next_pixel();
        @(negedge clk);
        hsync_fell = prev_hsync && !vga_hsync;
        hsync_rose = !prev_hsync && vga_hsync;
        vsync_fell = prev_vsync && !vga_vsync;
        vsync_rose = !prev_vsync && vga_vsync;
        prev_hsync = vga_hsync;
        prev_vsync = vga_vsync;
        if (pix_valid) begin
            if (pix_col == `H_TOTAL - 1) begin
                pix_col = 0;
                pix_row = (pix_row == `V_TOTAL - 1) ? 0 : pix_row + 1;
            end else begin
                pix_col = pix_col + 1;
            end
            if (hsync_fell) begin
                assert (pix_col == HSYNC_COL)
                    else report_mismatch("column at hsync fall", pix_col, HSYNC_COL);
            end
            if (vsync_fell) begin
                assert (pix_row == VSYNC_ROW && pix_col == 0)
                    else report_failure("vsync fell away from the start of its line");
            end
        end
    endtask

    task automatic wait_frame_start();
        if (!(pix_row == VSYNC_ROW && pix_col == 0)) begin
            do begin
                next_pixel();
            end while (!vsync_fell);
        end
    endtask

    task automatic check_idle_outputs();
        assert (vga_hsync === 1'b1) else report_mismatch("vga_hsync", vga_hsync, 1);
        assert (vga_vsync === 1'b1) else report_mismatch("vga_vsync", vga_vsync, 1);
        assert (vga_de === 1'b0) else report_mismatch("vga_de", vga_de, 0);
        assert (vga_rgb === '0) else report_mismatch("vga_rgb", vga_rgb, 0);
    endtask

    task automatic check_reset_state();
        repeat (RESET_CYCLES) begin
            next_pixel();
            check_idle_outputs();
        end
        arst_n = 1'b1;
        next_pixel();               // overlay register still holds reset values
        check_idle_outputs();
        next_pixel();
        assert (vga_de === 1'b1) else report_mismatch("vga_de", vga_de, 1);
        pix_row   = 0;              // row 0, col 0 is the first pixel
        pix_col   = 0;
        pix_valid = 1'b1;
    endtask

    task automatic check_scan_timing();
        int frame_cycles;
        int hs_period;
        int hs_low;
        int vs_low;
        int line_de;
        int de_lines;
        bit seen_hfall;
        bit exp_de;
        wait_frame_start();
        frame_cycles = 0;
        hs_period    = 0;
        hs_low       = 0;
        vs_low       = 1;           // the frame start cycle is already low
        line_de      = 0;
        de_lines     = 0;
        seen_hfall   = 1'b0;
        do begin
            next_pixel();
            frame_cycles++;
            hs_period++;
            exp_de = (pix_row < `V_ACTIVE) && (pix_col < `H_ACTIVE);
            assert (vga_de === exp_de) else report_mismatch("vga_de", vga_de, exp_de);
            if (vga_de) line_de++;
            if (!vga_hsync) hs_low++;
            if (!vga_vsync) vs_low++;
            if (hsync_fell) begin
                if (seen_hfall) begin
                    assert (hs_period == `H_TOTAL)
                        else report_mismatch("hsync period", hs_period, `H_TOTAL);
                end
                if (line_de != 0) begin
                    assert (line_de == `H_ACTIVE)
                        else report_mismatch("de cycles per line", line_de, `H_ACTIVE);
                    de_lines++;
                end
                seen_hfall = 1'b1;
                hs_period  = 0;
                line_de    = 0;
            end
            if (hsync_rose) begin
                assert (hs_low == `H_SYNC) else report_mismatch("hsync low", hs_low, `H_SYNC);
                hs_low = 0;
            end
            if (vsync_rose) begin
                assert (vs_low == `V_SYNC * `H_TOTAL)
                    else report_mismatch("vsync low cycles", vs_low, `V_SYNC * `H_TOTAL);
            end
        end while (!vsync_fell);
        assert (frame_cycles == `H_TOTAL * `V_TOTAL)
            else report_mismatch("frame cycles", frame_cycles, `H_TOTAL * `V_TOTAL);
        assert (de_lines == `V_ACTIVE) else report_mismatch("de lines", de_lines, `V_ACTIVE);
    endtask

    // one frame from a frame start to the next, pulsing at pulse_row if it is reached
    task automatic scan_frame(input bit expect_text, input int pulse_row);
        int dx;
        int dy;
        bit in_glyph;
        int text_cnt;
        int bar_cnt;
        text_cnt = 0;
        bar_cnt  = 0;
        do begin
            next_pixel();
            tspin_detected = (pix_row == pulse_row) && (pix_col == PULSE_COL);
            dx = pix_col - `TSPIN_HSTART;
            dy = pix_row - `TSPIN_VSTART;
            in_glyph = (dx >= 0) && (dx < `TSPIN_HEND - `TSPIN_HSTART) &&
                       (dy >= 0) && (dy < `TSPIN_VEND - `TSPIN_VSTART) &&
                       (dx % `GLYPH_PITCH_COL < GLYPH_W) && (dy % `GLYPH_PITCH_ROW < GLYPH_H);
            // top line has five glyphs, the last three slots are empty
            if (dy < `GLYPH_PITCH_ROW && dx >= 5 * `GLYPH_PITCH_COL) in_glyph = 1'b0;
            if (vga_de) begin
                if (!expect_text || !in_glyph) begin
                    assert (vga_rgb === `BG_COLOR)
                        else report_mismatch("vga_rgb", vga_rgb, `BG_COLOR);
                end else if (dy < `GLYPH_SCALE && dx < GLYPH_W) begin
                    assert (vga_rgb === `TEXT_COLOR)   // top bar of the first T
                        else report_mismatch("vga_rgb", vga_rgb, `TEXT_COLOR);
                    bar_cnt++;
                end else begin
                    assert (vga_rgb === `BG_COLOR || vga_rgb === `TEXT_COLOR)
                        else report_failure("glyph pixel is neither text nor background");
                end
                if (vga_rgb === `TEXT_COLOR) text_cnt++;
            end
        end while (!vsync_fell);
        if (expect_text) begin
            assert (bar_cnt == `GLYPH_SCALE * GLYPH_W)
                else report_mismatch("top bar pixels", bar_cnt, `GLYPH_SCALE * GLYPH_W);
            assert (text_cnt > bar_cnt)
                else report_failure("alert frame shows no text beyond the first bar");
        end
    endtask

    task automatic check_no_alert();
        wait_frame_start();
        scan_frame(1'b0, NO_PULSE);
    endtask

    task automatic check_alert_text();
        wait_frame_start();
        scan_frame(1'b1, VSYNC_ROW);    // pulse just after the frame start
    endtask

    task automatic check_hold_and_restart();
        wait_frame_start();
        scan_frame(1'b1, NO_PULSE);     // between the first and second frame start
        scan_frame(1'b0, NO_PULSE);
        scan_frame(1'b1, VSYNC_ROW);
        scan_frame(1'b1, RESTART_ROW);  // second pulse restarts the count
        scan_frame(1'b1, NO_PULSE);
        scan_frame(1'b0, NO_PULSE);
    endtask

    initial begin
        #(TIMEOUT_NS);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        tspin_detected = 1'b0;
        pix_row        = 0;
        pix_col        = 0;
        pix_valid      = 1'b0;
        prev_hsync     = 1'b1;
        prev_vsync     = 1'b1;
        check_reset_state();
        check_scan_timing();
        check_no_alert();
        check_alert_text();
        check_hold_and_restart();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- tb/tspin_alert_asserts.sv
// output checks for the alert display top, attached with bind
// sync widths and alert latency follow the display defines
`timescale 1ns/1ps
`include "display_defines.svh"

module tspin_alert_asserts (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 tspin_detected,
    input logic                 alert,
    input display_pkg::rgb_t    vga_rgb,
    input logic                 vga_hsync,
    input logic                 vga_vsync,
    input logic                 vga_de
);
    int hsync_low_cnt;      // consecutive cycles of hsync low so far

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hsync_low_cnt <= 0;
        end else if (!vga_hsync) begin
            hsync_low_cnt <= hsync_low_cnt + 1;
        end else begin
            hsync_low_cnt <= 0;
        end
    end

    // a high sample after a low run ends the sync pulse
    hsync_width: assert property (@(posedge clk) disable iff (!arst_n)
        (vga_hsync && hsync_low_cnt != 0) |-> (hsync_low_cnt == `H_SYNC))
        else $error("hsync low width differs from H_SYNC");

    de_outside_sync: assert property (@(posedge clk) disable iff (!arst_n)
        vga_de |-> (vga_hsync && vga_vsync))
        else $error("de high during a sync pulse");

    rgb_blank: assert property (@(posedge clk) disable iff (!arst_n)
        !vga_de |-> (vga_rgb == '0))
        else $error("rgb not zero while de is low");

    alert_latency: assert property (@(posedge clk) disable iff (!arst_n)
        tspin_detected |=> alert)
        else $error("alert did not follow the detection pulse");

endmodule

bind tspin_alert_display tspin_alert_asserts i_tspin_alert_asserts (
    .clk            (clk),
    .arst_n         (arst_n),
    .tspin_detected (tspin_detected),
    .alert          (alert),
    .vga_rgb        (vga_rgb),
    .vga_hsync      (vga_hsync),
    .vga_vsync      (vga_vsync),
    .vga_de         (vga_de)
);

//--- src/tspin_alert_display.sv
// VGA alert overlay top; one pixel per clock, no back-pressure
// vga_rgb follows the scan position by one cycle
`timescale 1ns/1ps

module tspin_alert_display (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                tspin_detected,     // one-cycle pulse
    output display_pkg::rgb_t   vga_rgb,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output logic                vga_de
);
    logic alert;

    vga_scan_if scan ();

    vga_timing i_vga_timing (
        .clk            (clk),
        .arst_n         (arst_n),
        .scan           (scan.source)
    );

    tspin_alert_timer i_tspin_alert_timer (
        .clk            (clk),
        .arst_n         (arst_n),
        .tspin_detected (tspin_detected),
        .scan           (scan.sink),
        .alert          (alert)
    );

    tspin_text_overlay i_tspin_text_overlay (
        .clk            (clk),
        .arst_n         (arst_n),
        .alert          (alert),
        .scan           (scan.sink),
        .rgb            (vga_rgb),
        .de             (vga_de),
        .hsync          (vga_hsync),
        .vsync          (vga_vsync)
    );

endmodule

//--- src/tspin_text_overlay.sv
// draws "TSPIN" over "DETECTED" in the fixed box while alert is high
// outputs lag the scan interface by one cycle; rgb is 0 outside de
`timescale 1ns/1ps
`include "display_defines.svh"

module tspin_text_overlay (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    alert,
    vga_scan_if.sink                scan,
    output display_pkg::rgb_t       rgb,
    output logic                    de,
    output logic                    hsync,
    output logic                    vsync
);
    import display_pkg::*;
    import glyph_pkg::*;

    localparam int LINE0_LEN = 5;
    localparam int LINE1_LEN = 8;
    localparam logic [8*LINE0_LEN-1:0] LINE0_TEXT = "TSPIN";
    localparam logic [8*LINE1_LEN-1:0] LINE1_TEXT = "DETECTED";

    logic [LINE0_LEN-1:0] lit_line0;
    logic [LINE1_LEN-1:0] lit_line1;
    logic                 in_box;
    rgb_t                 pixel_color;

    for (genvar g = 0; g < LINE0_LEN; g++) begin : g_line0
        localparam char_code_t CH = LINE0_TEXT[8*(LINE0_LEN-1-g) +: 8];    // first char on the left
        glyph_render #(
            .SCALE      (`GLYPH_SCALE),
            .ORIGIN_ROW (`TSPIN_VSTART),
            .ORIGIN_COL (`TSPIN_HSTART + `GLYPH_PITCH_COL * g)
        ) i_glyph_render (
            .row        (scan.row),
            .col        (scan.col),
            .character  (CH),
            .lit        (lit_line0[g])
        );
    end

    for (genvar g = 0; g < LINE1_LEN; g++) begin : g_line1
        localparam char_code_t CH = LINE1_TEXT[8*(LINE1_LEN-1-g) +: 8];
        glyph_render #(
            .SCALE      (`GLYPH_SCALE),
            .ORIGIN_ROW (`TSPIN_VSTART + `GLYPH_PITCH_ROW),
            .ORIGIN_COL (`TSPIN_HSTART + `GLYPH_PITCH_COL * g)
        ) i_glyph_render (
            .row        (scan.row),
            .col        (scan.col),
            .character  (CH),
            .lit        (lit_line1[g])
        );
    end

    assign in_box = (scan.row >= `TSPIN_VSTART) && (scan.row < `TSPIN_VEND) &&
                    (scan.col >= `TSPIN_HSTART) && (scan.col < `TSPIN_HEND);

    always_comb begin
        if (!scan.de) begin
            pixel_color = '0;                   // blanking
        end else if (alert && in_box && (|{lit_line1, lit_line0})) begin
            pixel_color = `TEXT_COLOR;
        end else begin
            pixel_color = `BG_COLOR;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb   <= '0;
            de    <= 1'b0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= pixel_color;
            de    <= scan.de;       // syncs delayed to stay aligned with rgb
            hsync <= scan.hsync;
            vsync <= scan.vsync;
        end
    end

endmodule

//--- src/tspin_alert_timer.sv
// holds alert for ALERT_FRAMES frame starts after a detection pulse
// a frame start is the first cycle of vsync low; a new pulse restarts the hold
`timescale 1ns/1ps
`include "display_defines.svh"

module tspin_alert_timer (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        tspin_detected,
    vga_scan_if.sink    scan,
    output logic        alert
);
    import display_pkg::*;

    // counter only reaches ALERT_FRAMES - 1
    localparam int CNT_W = (`ALERT_FRAMES > 1) ? $clog2(`ALERT_FRAMES) : 1;

    alert_state_t     state;
    logic [CNT_W-1:0] frame_cnt;
    logic             vsync_q;
    logic             frame_start;

    assign frame_start = vsync_q && !scan.vsync;    // falling edge of vsync

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ALERT_IDLE;
            frame_cnt <= '0;
            vsync_q   <= 1'b1;
        end else begin
            vsync_q <= scan.vsync;
            case (state)
                ALERT_IDLE: begin
                    if (tspin_detected) begin
                        state     <= ALERT_SHOW;
                        frame_cnt <= '0;
                    end
                end
                ALERT_SHOW: begin
                    if (tspin_detected) begin
                        frame_cnt <= '0;                // restart the hold
                    end else if (frame_start) begin
                        if (frame_cnt == CNT_W'(`ALERT_FRAMES - 1)) begin
                            state     <= ALERT_IDLE;
                            frame_cnt <= '0;
                        end else begin
                            frame_cnt <= frame_cnt + 1'b1;
                        end
                    end
                end
                default: state <= ALERT_IDLE;
            endcase
        end
    end

    assign alert = (state == ALERT_SHOW);

endmodule

//--- src/glyph_render.sv
// one 5x7 character at a fixed origin; only T S P I N D E C are drawn
// cell covers origin up to origin + 5*SCALE columns and 7*SCALE rows, end exclusive
`timescale 1ns/1ps
`include "display_defines.svh"

module glyph_render #(
    parameter int SCALE      = 2,
    parameter int ORIGIN_ROW = 0,
    parameter int ORIGIN_COL = 0
) (
    input  display_pkg::scan_row_t  row,
    input  display_pkg::scan_col_t  col,
    input  glyph_pkg::char_code_t   character,
    output logic                    lit
);
    import display_pkg::*;
    import glyph_pkg::*;

    localparam int BITMAP_W = `FONT_COLS * `FONT_ROWS;

    scan_row_t             font_r;
    scan_col_t             font_c;
    logic                  in_cell;
    logic [BITMAP_W-1:0]   bitmap;      // font row 0 in the top five bits
    glyph_row_t            pattern;

    assign font_r = scan_row_t'((row - scan_row_t'(ORIGIN_ROW)) / SCALE);
    assign font_c = scan_col_t'((col - scan_col_t'(ORIGIN_COL)) / SCALE);

    // GEQ against the origin, strict against the cell end
    assign in_cell = (row >= ORIGIN_ROW) && (col >= ORIGIN_COL) &&
                     (font_r < `FONT_ROWS) && (font_c < `FONT_COLS);

    always_comb begin
        case (character)
            "T": bitmap = {5'b11111, 5'b00100, 5'b00100, 5'b00100,
                           5'b00100, 5'b00100, 5'b00100};
            "S": bitmap = {5'b01111, 5'b10000, 5'b10000, 5'b01110,
                           5'b00001, 5'b00001, 5'b11110};
            "P": bitmap = {5'b11110, 5'b10001, 5'b10001, 5'b11110,
                           5'b10000, 5'b10000, 5'b10000};
            "I": bitmap = {5'b01110, 5'b00100, 5'b00100, 5'b00100,
                           5'b00100, 5'b00100, 5'b01110};
            "N": bitmap = {5'b10001, 5'b11001, 5'b10101, 5'b10011,
                           5'b10001, 5'b10001, 5'b10001};
            "D": bitmap = {5'b11100, 5'b10010, 5'b10001, 5'b10001,
                           5'b10001, 5'b10010, 5'b11100};
            "E": bitmap = {5'b11111, 5'b10000, 5'b10000, 5'b11110,
                           5'b10000, 5'b10000, 5'b11111};
            "C": bitmap = {5'b01110, 5'b10001, 5'b10000, 5'b10000,
                           5'b10000, 5'b10001, 5'b01110};
            default: bitmap = '0;               // unknown codes are blank
        endcase
    end

    always_comb begin
        pattern = '0;
        lit     = 1'b0;
        if (in_cell) begin
            pattern = bitmap[(`FONT_ROWS - 1 - int'(font_r)) * `FONT_COLS +: `FONT_COLS];
            lit     = pattern[`FONT_COLS - 1 - int'(font_c)];   // leftmost is the top bit
        end
    end

endmodule

//--- src/vga_timing.sv
// fixed 640x480 raster; counters always run, no enable
// after reset the first pixel out is row 0, col 0
`timescale 1ns/1ps
`include "display_defines.svh"

module vga_timing (
    input  logic          clk,
    input  logic          arst_n,
    vga_scan_if.source    scan
);
    import display_pkg::*;

    scan_col_t h_cnt;   // position that the next registered pixel describes
    scan_row_t v_cnt;
    logic      h_last;
    logic      v_last;
    logic      de_next;
    logic      hsync_next;
    logic      vsync_next;

    assign h_last = (h_cnt == scan_col_t'(`H_TOTAL - 1));
    assign v_last = (v_cnt == scan_row_t'(`V_TOTAL - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            h_cnt <= h_last ? '0 : h_cnt + 1'b1;
            if (h_last) begin
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
        end
    end

    // decode from the counters so every output lands in the same register stage
    assign de_next    = (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
    assign hsync_next = !((h_cnt >= `H_ACTIVE + `H_FRONT) &&
                          (h_cnt <  `H_ACTIVE + `H_FRONT + `H_SYNC));
    assign vsync_next = !((v_cnt >= `V_ACTIVE + `V_FRONT) &&
                          (v_cnt <  `V_ACTIVE + `V_FRONT + `V_SYNC));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan.row   <= '0;
            scan.col   <= '0;
            scan.de    <= 1'b0;
            scan.hsync <= 1'b1;     // inactive
            scan.vsync <= 1'b1;
        end else begin
            scan.row   <= v_cnt;
            scan.col   <= h_cnt;
            scan.de    <= de_next;
            scan.hsync <= hsync_next;
            scan.vsync <= vsync_next;
        end
    end

endmodule

//--- src/vga_scan_if.sv
// scan position plus sync and blanking, all valid every cycle
// syncs are active low
`timescale 1ns/1ps

interface vga_scan_if;
    import display_pkg::*;

    scan_row_t row;
    scan_col_t col;
    logic      de;
    logic      hsync;
    logic      vsync;

    modport source (output row, col, de, hsync, vsync);
    modport sink   (input  row, col, de, hsync, vsync);

endinterface

//--- src/glyph_pkg.sv
// font types; codes are plain 8-bit ASCII
// a font row holds the leftmost pixel in its top bit
`include "display_defines.svh"

package glyph_pkg;

    typedef logic [7:0] char_code_t;

    typedef logic [`FONT_COLS-1:0] glyph_row_t;

endpackage

//--- src/display_pkg.sv
// screen coordinate, colour and alert state types
// widths come from the display defines
`include "display_defines.svh"

package display_pkg;

    typedef logic [`SCAN_W-1:0] scan_row_t;
    typedef logic [`SCAN_W-1:0] scan_col_t;

    // red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [`RGB_W-1:0] rgb_t;

    typedef enum logic {
        ALERT_IDLE,
        ALERT_SHOW
    } alert_state_t;

endpackage

//--- src/display_defines.svh
// 640x480 timing at one pixel per clock; text box and colours are fixed
// TSPIN_HEND/VEND assume 8 glyphs across and 2 text lines
`ifndef DISPLAY_DEFINES_SVH
`define DISPLAY_DEFINES_SVH

`define SCAN_W          10          // wide enough for H_TOTAL and V_TOTAL
`define RGB_W           24

`define H_ACTIVE        640
`define H_FRONT         16
`define H_SYNC          96
`define H_BACK          48
`define H_TOTAL         800

`define V_ACTIVE        480
`define V_FRONT         10
`define V_SYNC          2
`define V_BACK          33
`define V_TOTAL         525

// text box, top-left corner and glyph spacing
`define TSPIN_HSTART    264
`define TSPIN_VSTART    224
`define GLYPH_SCALE     2
`define GLYPH_PITCH_COL 14
`define GLYPH_PITCH_ROW 16
`define TSPIN_HEND      (`TSPIN_HSTART + 8 * `GLYPH_PITCH_COL)
`define TSPIN_VEND      (`TSPIN_VSTART + 2 * `GLYPH_PITCH_ROW)

`define FONT_COLS       5
`define FONT_ROWS       7

`define BG_COLOR        24'h10_1020
`define TEXT_COLOR      24'hff_ffff
`define ALERT_FRAMES    2           // frame starts counted before the alert drops

`endif
